/* design/tcb_csr.sv */
////////////////////////////////////////
// register block subordinate, ID register
// and two scratch registers
////////////////////////////////////////

`timescale 1ns/1ns

module tcb_csr #(
  parameter int DAT_W = 32
) (
  tcb_if.sbr bus
);

  localparam int BEN_W = DAT_W/8;

  logic [1:0]       ofs;
  logic             bad;
  logic             xfer;
  logic [DAT_W-1:0] rd_val;
  // scratch registers
  logic [DAT_W-1:0] scr0;
  logic [DAT_W-1:0] scr1;
  // registered response
  logic [DAT_W-1:0] rdt_q;
  logic             err_q;

  ////////////////////////////////////////
  // decode
  ////////////////////////////////////////

  assign ofs  = bus.adr[1:0];
  assign xfer = bus.vld & bus.rdy;

  // ID is read only, offset 3 does not exist
  assign bad = ((ofs == tcb_pkg::CSR_OFS_ID) && bus.wen) ||
               ((ofs != tcb_pkg::CSR_OFS_ID) && (ofs != tcb_pkg::CSR_OFS_SCR0) &&
                (ofs != tcb_pkg::CSR_OFS_SCR1));

  // read mux, the unmapped offset reads zero
  always_comb begin
    case (ofs)
      tcb_pkg::CSR_OFS_ID:   rd_val = DAT_W'(tcb_pkg::CSR_ID);
      tcb_pkg::CSR_OFS_SCR0: rd_val = scr0;
      tcb_pkg::CSR_OFS_SCR1: rd_val = scr1;
      default:               rd_val = '0;
    endcase
  end

  // scratch writes, lane by lane
  always_ff @(posedge bus.sub or negedge bus.rst_n) begin
    if (!bus.rst_n) begin
      scr0 <= '0;
      scr1 <= '0;
    end else if (xfer && bus.wen) begin
      for (int i = 0; i < BEN_W; i++) begin
        if (bus.ben[i] && (ofs == tcb_pkg::CSR_OFS_SCR0)) begin
          scr0[8*i +: 8] <= bus.wdt[8*i +: 8];
        end
        if (bus.ben[i] && (ofs == tcb_pkg::CSR_OFS_SCR1)) begin
          scr1[8*i +: 8] <= bus.wdt[8*i +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////
  // response
  ////////////////////////////////////////

  // error flag only for the cycle after a failed access
  always_ff @(posedge bus.sub or negedge bus.rst_n) begin
    if (!bus.rst_n) begin
      err_q <= 1'b0;
    end else begin
      err_q <= xfer & bad;
    end
  end

  // writes and errors return zero data
  always_ff @(posedge bus.sub) begin
    if (xfer) begin
      rdt_q <= (bus.wen || bad) ? '0 : rd_val;
    end
  end

  assign bus.rdy = 1'b1;
  assign bus.rdt = rdt_q;
  assign bus.err = err_q;

endmodule

/* design/tcb_decoder.sv */
////////////////////////////////////////
// address decoder with response routing
// for the memory and register subordinates
////////////////////////////////////////

`timescale 1ns/1ns

module tcb_decoder #(
  parameter int ADR_W = 10
) (
  // from the register slice
  tcb_if.sbr up,
  // memory region, address msb low
  tcb_if.mgr mem,
  // register region, address msb high
  tcb_if.mgr csr
);

  // select of the current request
  tcb_pkg::tcb_sel_t sel;
  // owner of the response that is due this cycle
  tcb_pkg::tcb_sel_t sel_q;
  logic              xfer;

  ////////////////////////////////////////
  // request routing
  ////////////////////////////////////////

  // region comes straight from the top address bit
  assign sel = tcb_pkg::tcb_sel_t'(up.adr[ADR_W-1]);

  // valid goes only to the selected subordinate
  assign mem.vld = up.vld & (sel == tcb_pkg::sel_mem);
  assign csr.vld = up.vld & (sel == tcb_pkg::sel_csr);

  // request fields are shared, valid qualifies them
  assign mem.wen = up.wen;
  assign mem.adr = up.adr;
  assign mem.ben = up.ben;
  assign mem.wdt = up.wdt;
  assign csr.wen = up.wen;
  assign csr.adr = up.adr;
  assign csr.ben = up.ben;
  assign csr.wdt = up.wdt;

  // ready of the addressed subordinate
  assign up.rdy = (sel == tcb_pkg::sel_mem) ? mem.rdy : csr.rdy;

  assign xfer = up.vld & up.rdy;

  ////////////////////////////////////////
  // response routing
  ////////////////////////////////////////

  // one entry is enough for a response delay of one cycle
  // a new transfer may overwrite it in the same cycle its response leaves
  always_ff @(posedge up.sub or negedge up.rst_n) begin
    if (!up.rst_n) begin
      sel_q <= tcb_pkg::sel_mem;
    end else if (xfer) begin
      sel_q <= sel;
    end
  end

  // response of the subordinate that owned the previous transfer
  assign up.rdt = (sel_q == tcb_pkg::sel_mem) ? mem.rdt : csr.rdt;
  assign up.err = (sel_q == tcb_pkg::sel_mem) ? mem.err : csr.err;

  // never address both subordinates in one cycle
  assert property (@(posedge up.sub) disable iff (!up.rst_n)
    $onehot0({mem.vld, csr.vld}));

endmodule

/* design/tcb_if.sv */
////////////////////////////////////////
// TCB interface with mgr and sbr modports
////////////////////////////////////////

`timescale 1ns/1ns

interface tcb_if #(
  parameter int ADR_W = 10,
  parameter int DAT_W = 32,
  // response delay in cycles after the transfer
  parameter int DLY   = 1
) (
  input logic sub,
  input logic rst_n
);

  // handshake
  logic             vld;
  logic             rdy;
  // request
  logic             wen;
  logic [ADR_W-1:0] adr;
  logic [DAT_W/8-1:0] ben;
  logic [DAT_W-1:0] wdt;
  // response, sampled DLY cycles after the transfer
  logic [DAT_W-1:0] rdt;
  logic             err;

  // manager side drives the request
  modport mgr (
    input  sub, rst_n,
    output vld, wen, adr, ben, wdt,
    input  rdy, rdt, err
  );

  // subordinate side answers it
  modport sbr (
    input  sub, rst_n,
    input  vld, wen, adr, ben, wdt,
    output rdy, rdt, err
  );

  // the error flag must be known once the response delay has passed
  assert property (@(posedge sub) disable iff (!rst_n)
    (vld && rdy) |-> ##DLY !$isunknown(err));

endinterface

/* design/tcb_memory.sv */
////////////////////////////////////////
// word memory subordinate with byte enables
////////////////////////////////////////

`timescale 1ns/1ns

module tcb_memory #(
  parameter int DAT_W  = 32,
  parameter int MEM_AW = 8
) (
  tcb_if.sbr bus
);

  localparam int BEN_W = DAT_W/8;

  // storage array, addresses wrap at the depth
  logic [DAT_W-1:0]  mem [2**MEM_AW];
  logic [MEM_AW-1:0] idx;
  logic [DAT_W-1:0]  rdt_q;

  assign idx = bus.adr[MEM_AW-1:0];

  ////////////////////////////////////////
  // write and read ports
  ////////////////////////////////////////

  // write, only enabled lanes change
  always_ff @(posedge bus.sub) begin
    if (bus.vld && bus.wen) begin
      for (int i = 0; i < BEN_W; i++) begin
        if (bus.ben[i]) begin
          mem[idx][8*i +: 8] <= bus.wdt[8*i +: 8];
        end
      end
    end
  end

  // read, word is presented one cycle later
  always_ff @(posedge bus.sub) begin
    if (bus.vld && !bus.wen) begin
      rdt_q <= mem[idx];
    end
  end

  // always ready, never fails
  assign bus.rdy = 1'b1;
  assign bus.rdt = rdt_q;
  assign bus.err = 1'b0;

  // an unknown address would corrupt or read an arbitrary word
  assert property (@(posedge bus.sub) disable iff (!bus.rst_n)
    bus.vld |-> !$isunknown(bus.adr));

endmodule

/* design/tcb_pkg.sv */
////////////////////////////////////////
// shared address map, ID value and
// subordinate select type for the TCB subsystem
////////////////////////////////////////

package tcb_pkg;

  ////////////////////////////////////////
  // subordinate select
  ////////////////////////////////////////

  // owner of a request, taken from the address msb
  typedef enum logic {
    sel_mem = 1'b0,
    sel_csr = 1'b1
  } tcb_sel_t;

  ////////////////////////////////////////
  // register region map
  ////////////////////////////////////////

  // fixed value returned by the ID register
  localparam logic [31:0] CSR_ID = 32'h7cb0_0101;

  // word offsets inside the register region
  localparam logic [1:0] CSR_OFS_ID   = 2'd0;
  localparam logic [1:0] CSR_OFS_SCR0 = 2'd1;
  localparam logic [1:0] CSR_OFS_SCR1 = 2'd2;
  // offset 3 is left unmapped and answers with an error

endpackage

/* design/tcb_register_request.sv */
////////////////////////////////////////
// request path register slice, one cycle
// of delay without bubbles
////////////////////////////////////////

`timescale 1ns/1ns

module tcb_register_request (
  // upstream side, the manager connects here
  tcb_if.sbr up,
  // downstream side, toward the decoder
  tcb_if.mgr dn
);

  ////////////////////////////////////////
  // handshake
  ////////////////////////////////////////

  // output slot is refilled whenever upstream may hand over
  always_ff @(posedge up.sub or negedge up.rst_n) begin
    if (!up.rst_n) begin
      dn.vld <= 1'b0;
    end else if (up.rdy) begin
      dn.vld <= up.vld;
    end
  end

  // ready when downstream takes the held item or the slot is empty
  assign up.rdy = dn.rdy | ~dn.vld;

  ////////////////////////////////////////
  // request payload
  ////////////////////////////////////////

  // capture only on a real transfer, so a stall keeps the fields
  always_ff @(posedge up.sub) begin
    if (up.vld && up.rdy) begin
      dn.wen <= up.wen;
      dn.adr <= up.adr;
      dn.ben <= up.ben;
      dn.wdt <= up.wdt;
    end
  end

  // response is not registered here
  assign up.rdt = dn.rdt;
  assign up.err = dn.err;

  // a held request must not change until it is taken
  assert property (@(posedge up.sub) disable iff (!up.rst_n)
    (dn.vld && !dn.rdy) |=> dn.vld && $stable({dn.wen, dn.adr, dn.ben, dn.wdt}));

endmodule

/* design/tcb_subsystem.sv */
////////////////////////////////////////
// TCB subsystem top, slice, decoder,
// memory and register block
////////////////////////////////////////

`timescale 1ns/1ns

module tcb_subsystem #(
  parameter int ADR_W  = 10,
  parameter int DAT_W  = 32,
  parameter int MEM_AW = 8
) (
  input  logic               sub,
  input  logic               rst_n,
  // request from the external manager
  input  logic               vld,
  input  logic               wen,
  input  logic [ADR_W-1:0]   adr,
  input  logic [DAT_W/8-1:0] ben,
  input  logic [DAT_W-1:0]   wdt,
  // handshake and response back to it
  output logic               rdy,
  output logic [DAT_W-1:0]   rdt,
  output logic               err
);

  ////////////////////////////////////////
  // bus links
  ////////////////////////////////////////

  // top port, response two cycles after the transfer
  tcb_if #(.ADR_W(ADR_W), .DAT_W(DAT_W), .DLY(2)) bus_top (.sub(sub), .rst_n(rst_n));
  // slice to decoder
  tcb_if #(.ADR_W(ADR_W), .DAT_W(DAT_W), .DLY(1)) bus_dec (.sub(sub), .rst_n(rst_n));
  // decoder to each subordinate
  tcb_if #(.ADR_W(ADR_W), .DAT_W(DAT_W), .DLY(1)) bus_mem (.sub(sub), .rst_n(rst_n));
  tcb_if #(.ADR_W(ADR_W), .DAT_W(DAT_W), .DLY(1)) bus_csr (.sub(sub), .rst_n(rst_n));

  // plain ports onto the top link
  assign bus_top.vld = vld;
  assign bus_top.wen = wen;
  assign bus_top.adr = adr;
  assign bus_top.ben = ben;
  assign bus_top.wdt = wdt;
  assign rdy = bus_top.rdy;
  assign rdt = bus_top.rdt;
  assign err = bus_top.err;

  ////////////////////////////////////////
  // blocks
  ////////////////////////////////////////

  tcb_register_request u_slice (.up(bus_top), .dn(bus_dec));

  tcb_decoder #(.ADR_W(ADR_W)) u_dec (.up(bus_dec), .mem(bus_mem), .csr(bus_csr));

  tcb_memory #(.DAT_W(DAT_W), .MEM_AW(MEM_AW)) u_mem (.bus(bus_mem));

  tcb_csr #(.DAT_W(DAT_W)) u_csr (.bus(bus_csr));

endmodule

/* files.f */
design/tcb_pkg.sv
design/tcb_if.sv
design/tcb_register_request.sv
design/tcb_decoder.sv
design/tcb_memory.sv
design/tcb_csr.sv
design/tcb_subsystem.sv
test/tb_tcb_subsystem.sv

/* run.sh */
#!/bin/sh
# build the TCB subsystem testbench with Verilator and run it
# the exit status is the simulator's, non zero on any failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_tcb_subsystem \
  --Mdir obj_dir -o tb_tcb_subsystem \
  -f files.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/tb_tcb_subsystem
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi

exit 0

/* test/tb_tcb_subsystem.sv */
////////////////////////////////////////
// testbench for the TCB subsystem, LFSR
// stimulus, reference model and checks
////////////////////////////////////////

`timescale 1ns/1ns

module tb_tcb_subsystem;

  localparam int ADR_W  = 10;
  localparam int DAT_W  = 32;
  localparam int MEM_AW = 8;
  localparam int BEN_W  = DAT_W/8;
  localparam int T_CLK  = 40;
  localparam int T_DRV  = 2;
  // transfer counts, the cycle limit is built from them
  localparam int N_FILL   = 2**MEM_AW;
  localparam int N_DIRECT = 80;
  localparam int N_RAND   = 400;
  localparam int LIMIT    = N_FILL + N_DIRECT + N_RAND + 50;
  // address bit just above the memory depth, used to alias words
  localparam logic [ADR_W-2:0] WRAP = (ADR_W-1)'(1 << MEM_AW);

  // one expected response, due in a given cycle
  typedef struct packed {
    logic [31:0]      due;
    logic [DAT_W-1:0] rdt;
    logic             err;
    logic             chk;
  } exp_t;

  logic             sub;
  logic             rst_n;
  logic             vld;
  logic             wen;
  logic [ADR_W-1:0] adr;
  logic [BEN_W-1:0] ben;
  logic [DAT_W-1:0] wdt;
  logic             rdy;
  logic [DAT_W-1:0] rdt;
  logic             err;

  int               cycle = 0;
  logic [15:0]      lfsr  = 16'd36084;
  exp_t             exp_q[$];
  // reference model state
  logic [DAT_W-1:0] mem_m [2**MEM_AW];
  logic [DAT_W-1:0] scr0_m;
  logic [DAT_W-1:0] scr1_m;

  tcb_subsystem #(.ADR_W(ADR_W), .DAT_W(DAT_W), .MEM_AW(MEM_AW)) dut (
    .sub(sub), .rst_n(rst_n),
    .vld(vld), .wen(wen), .adr(adr), .ben(ben), .wdt(wdt),
    .rdy(rdy), .rdt(rdt), .err(err)
  );

  initial begin
    sub = 1'b0;
    forever #(T_CLK/2) sub = ~sub;
  end

  // cycle number, also the base of the timeout
  always @(posedge sub) cycle <= cycle + 1;

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  // fibonacci step, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // n fresh bits, one step per bit
  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [ADR_W-1:0] csr_adr(input logic [1:0] ofs);
    return {1'b1, {(ADR_W-3){1'b0}}, ofs};
  endfunction

  function automatic logic [ADR_W-1:0] mem_adr(input logic [ADR_W-2:0] a);
    return {1'b0, a};
  endfunction

  // odd multiplier, every address gets its own word
  function automatic logic [DAT_W-1:0] fill_word(input int i);
    return DAT_W'(32'h9e37_79b9 * 32'(i + 1));
  endfunction

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic logic [DAT_W-1:0] merge_lanes(input logic [DAT_W-1:0] old,
      input logic [BEN_W-1:0] b, input logic [DAT_W-1:0] d);
    logic [DAT_W-1:0] res;
    res = old;
    for (int i = 0; i < BEN_W; i++) begin
      if (b[i]) res[8*i +: 8] = d[8*i +: 8];
    end
    return res;
  endfunction

  // updates the model and gives the response of one transfer
  function automatic void ref_xfer(input logic w, input logic [ADR_W-1:0] a,
      input logic [BEN_W-1:0] b, input logic [DAT_W-1:0] d, output exp_t e);
    tcb_pkg::tcb_sel_t region;
    logic [MEM_AW-1:0] idx;
    logic [1:0]        ofs;
    region = tcb_pkg::tcb_sel_t'(a[ADR_W-1]);
    idx    = a[MEM_AW-1:0];
    ofs    = a[1:0];
    e      = '0;
    if (region == tcb_pkg::sel_mem) begin
      // memory never fails, read data after a write is undefined
      e.chk = !w;
      if (w) mem_m[idx] = merge_lanes(mem_m[idx], b, d);
      else e.rdt = mem_m[idx];
    end else begin
      // register writes and errors answer with zero
      e.chk = 1'b1;
      case (ofs)
        tcb_pkg::CSR_OFS_ID: begin
          if (w) e.err = 1'b1;
          else e.rdt = DAT_W'(tcb_pkg::CSR_ID);
        end
        tcb_pkg::CSR_OFS_SCR0: begin
          if (w) scr0_m = merge_lanes(scr0_m, b, d);
          else e.rdt = scr0_m;
        end
        tcb_pkg::CSR_OFS_SCR1: begin
          if (w) scr1_m = merge_lanes(scr1_m, b, d);
          else e.rdt = scr1_m;
        end
        default: e.err = 1'b1;
      endcase
    end
  endfunction

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  task automatic check_data(input string name, input logic [DAT_W-1:0] exp_v,
      input logic [DAT_W-1:0] act);
    if (act !== exp_v) begin
      $display("CHECK FAILED time=%0t %s expected=%h actual=%h", $time, name, exp_v, act);
      $display("STATUS: FAIL");
      $fatal(1, "wrong value on %s", name);
    end
  endtask

  task automatic check_flag(input string name, input logic exp_v, input logic act);
    if (act !== exp_v) begin
      $display("CHECK FAILED time=%0t %s expected=%b actual=%b", $time, name, exp_v, act);
      $display("STATUS: FAIL");
      $fatal(1, "wrong value on %s", name);
    end
  endtask

  // responses are stable mid cycle, two cycles after acceptance
  always @(negedge sub) begin : compare
    exp_t e;
    while (exp_q.size() > 0 && exp_q[0].due == 32'(cycle)) begin
      e = exp_q.pop_front();
      if (e.chk) check_data("rdt", e.rdt, rdt);
      check_flag("err", e.err, err);
    end
  end

  initial begin
    wait (cycle >= LIMIT);
    $display("timeout, the test did not end within %0d cycles", LIMIT);
    $display("STATUS: FAIL");
    $fatal(1, "timeout");
  end

  ////////////////////////////////////////
  // bus driver
  ////////////////////////////////////////

  // starts and ends 2 ns after a rising edge
  task automatic xfer(input logic w, input logic [ADR_W-1:0] a,
      input logic [BEN_W-1:0] b, input logic [DAT_W-1:0] d);
    exp_t e;
    vld = 1'b1;
    wen = w;
    adr = a;
    ben = b;
    wdt = d;
    @(negedge sub);
    // hold the request until the port takes it
    while (rdy !== 1'b1) begin
      @(negedge sub);
    end
    ref_xfer(w, a, b, d, e);
    e.due = 32'(cycle + 2);
    exp_q.push_back(e);
    @(posedge sub);
    #T_DRV;
  endtask

  task automatic idle(input int n);
    vld = 1'b0;
    repeat (n) begin
      @(posedge sub);
      #T_DRV;
    end
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    logic [31:0] r_ctl;
    logic [31:0] r_adr;
    logic [31:0] r_ben;
    logic [31:0] r_wdt;
    rst_n  = 1'b0;
    vld    = 1'b0;
    wen    = 1'b0;
    adr    = '0;
    ben    = '0;
    wdt    = '0;
    scr0_m = '0;
    scr1_m = '0;
    repeat (2) @(posedge sub);
    #T_DRV;
    rst_n = 1'b1;

    // reset values
    check_flag("rdy", 1'b1, rdy);
    xfer(1'b0, csr_adr(tcb_pkg::CSR_OFS_SCR0), '0, '0);
    xfer(1'b0, csr_adr(tcb_pkg::CSR_OFS_SCR1), '0, '0);
    xfer(1'b0, csr_adr(tcb_pkg::CSR_OFS_ID), '0, '0);

    // whole memory gets a known word first
    for (int i = 0; i < N_FILL; i++) begin
      xfer(1'b1, mem_adr((ADR_W-1)'(i)), '1, fill_word(i));
    end

    // partial write through an alias, read at the base address
    for (int k = 0; k < 16; k++) begin
      take_bits(MEM_AW, r_adr);
      take_bits(BEN_W, r_ben);
      take_bits(DAT_W, r_wdt);
      xfer(1'b1, mem_adr((ADR_W-1)'(r_adr[MEM_AW-1:0]) | WRAP), BEN_W'(r_ben), r_wdt);
      xfer(1'b0, mem_adr((ADR_W-1)'(r_adr[MEM_AW-1:0])), '0, '0);
    end

    // ID write and the unmapped offset fail, scratch keeps its value
    xfer(1'b1, csr_adr(tcb_pkg::CSR_OFS_SCR0), '1, 32'hc0de_5a5a);
    xfer(1'b1, csr_adr(tcb_pkg::CSR_OFS_ID), '1, 32'hffff_ffff);
    xfer(1'b1, csr_adr(2'd3), '1, 32'h1234_5678);
    xfer(1'b0, csr_adr(2'd3), '0, '0);
    xfer(1'b0, csr_adr(tcb_pkg::CSR_OFS_ID), '0, '0);
    xfer(1'b0, csr_adr(tcb_pkg::CSR_OFS_SCR0), '0, '0);
    xfer(1'b0, csr_adr(tcb_pkg::CSR_OFS_SCR1), '0, '0);

    // back to back, switching region every cycle
    for (int k = 0; k < 8; k++) begin
      take_bits(MEM_AW, r_adr);
      take_bits(DAT_W, r_wdt);
      xfer(1'b1, mem_adr((ADR_W-1)'(r_adr[MEM_AW-1:0])), '1, r_wdt);
      xfer(1'b0, csr_adr(tcb_pkg::CSR_OFS_SCR1), '0, '0);
      xfer(1'b0, mem_adr((ADR_W-1)'(r_adr[MEM_AW-1:0])), '0, '0);
      xfer(1'b1, csr_adr(tcb_pkg::CSR_OFS_SCR1), '1, ~r_wdt);
    end

    // random mix over both regions
    for (int k = 0; k < N_RAND; k++) begin
      take_bits(1, r_ctl);
      take_bits(ADR_W, r_adr);
      take_bits(BEN_W, r_ben);
      take_bits(DAT_W, r_wdt);
      xfer(r_ctl[0], ADR_W'(r_adr), BEN_W'(r_ben), r_wdt);
    end

    // let the last responses drain
    idle(3);
    if (exp_q.size() != 0) begin
      $display("%0d responses were never checked", exp_q.size());
      $display("STATUS: FAIL");
      $fatal(1, "responses left in the queue");
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule
